/* run_sim.sh */
#!/bin/bash
# Build the testbench with Verilator, run it, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_logger \
  -f vlog.f -o sim_axi_logger &&
{ ./obj_dir/sim_axi_logger > sim.log 2>&1 ||
  echo "Simulator returned a failure status" >> sim.log; } &&
cat sim.log &&
grep -q "Finished with no errors" sim.log &&
! grep -q "Finished with errors" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tb/logger_checker.sv */
`timescale 1ns/10ps
`include "logger_config.svh"

module logger_checker (
  input  logic                  Clk_CI,
  input  logic                  rst,
  input  logic                  axi_valid,
  input  logic                  axi_ready,
  input  logger_pkg::axi_id_t   axi_id,
  input  logger_pkg::axi_addr_t axi_addr,
  input  logger_pkg::axi_len_t  axi_len,
  input  logic                  clear,
  input  logic                  full,
  input  logic                  rd_en,
  input  logger_pkg::log_addr_t rd_addr,
  input  logger_pkg::log_word_t rd_data,
  output int                    error_count
);

  localparam int WPE = `LOGGER_WORDS_PER_ENTRY;

  // Expected log contents per entry slot
  logger_pkg::timestamp_t ts_log   [`LOGGER_ENTRIES];
  logger_pkg::axi_addr_t  addr_log [`LOGGER_ENTRIES];
  logger_pkg::axi_id_t    id_log   [`LOGGER_ENTRIES];
  logger_pkg::axi_len_t   len_log  [`LOGGER_ENTRIES];

  logger_pkg::timestamp_t cycle_cnt;
  logger_pkg::axi_addr_t  beat_addr;
  logger_pkg::axi_id_t    beat_id;
  logger_pkg::axi_len_t   beat_len;
  logger_pkg::log_addr_t  rd_addr_q;
  logger_pkg::log_word_t  rd_exp;
  int                     seq;
  int                     wcnt;
  logic                   full_m;
  logic                   rst_q;
  logic                   rd_pending;

  // Word in entry 0 is the timestamp, 1 the address, 2 ID and length
  function automatic logger_pkg::log_word_t expected_word(input logger_pkg::log_addr_t a);
    int                    e;
    logger_pkg::log_word_t w;
    e = int'(a) / WPE;
    w = '0;
    case (int'(a) % WPE)
      0: w = ts_log[e];
      1: w = addr_log[e];
      default: begin
        w[15:8] = id_log[e];
        w[7:0]  = len_log[e];
      end
    endcase
    return w;
  endfunction

  initial begin
    error_count = 0;
    rst_q       = 1'b1;
    for (int i = 0; i < `LOGGER_ENTRIES; i++) begin
      ts_log[i]   = '0;
      addr_log[i] = '0;
      id_log[i]   = '0;
      len_log[i]  = '0;
    end
  end

  always @(posedge Clk_CI) begin
    logic exp_ready;
    logic offer;
    int   e;
    if (rst) begin
      seq        = 0;
      wcnt       = 0;
      full_m     = 1'b0;
      cycle_cnt  = '0;
      rd_pending = 1'b0;
    end else begin
      if (rst_q && rd_data !== '0) begin
        $display("** Error at %0d ns: rd_data is %h after reset, expected 0", $time, rd_data);
        error_count++;
      end
      if (rd_pending && rd_data !== rd_exp) begin
        $display("** Error at %0d ns: word %0d expected %h, read %h",
                 $time, rd_addr_q, rd_exp, rd_data);
        error_count++;
      end
      rd_pending = rd_en;
      if (rd_en) begin
        rd_addr_q = rd_addr;
        rd_exp    = expected_word(rd_addr);
      end

      exp_ready = (seq == 0) && !full_m && !clear;
      if (axi_ready && full) begin
        $display("Protocol failure at %0d ns: axi_ready is high while full is high", $time);
        error_count++;
      end else if (axi_ready !== exp_ready) begin
        $display("** Error at %0d ns: axi_ready is %b, expected %b", $time, axi_ready, exp_ready);
        error_count++;
      end
      if (full !== full_m) begin
        $display("** Error at %0d ns: full is %b, expected %b", $time, full, full_m);
        error_count++;
      end

      // Advance the model by one cycle
      offer = 1'b0;
      if (clear) begin
        seq    = 0;
        wcnt   = 0;
        full_m = 1'b0;
      end else if (seq == 0) begin
        if (axi_valid && exp_ready) begin
          beat_addr = axi_addr;
          beat_id   = axi_id;
          beat_len  = axi_len;
          offer     = 1'b1;
          seq       = 1;
        end
      end else begin
        offer = 1'b1;
        seq   = (seq == 1) ? 2 : 0;
      end
      if (offer) begin
        e = wcnt / WPE;
        case (wcnt % WPE)
          0: ts_log[e] = cycle_cnt;
          1: addr_log[e] = beat_addr;
          default: begin
            id_log[e]  = beat_id;
            len_log[e] = beat_len;
          end
        endcase
        wcnt++;
        if (wcnt == `LOGGER_WORDS) begin
          full_m = 1'b1;
        end
      end
      cycle_cnt = cycle_cnt + 1;
    end
    rst_q = rst;
  end

endmodule

/* tb/logger_sva.sv */
`timescale 1ns/10ps

module logger_sva (
  input logic Clk_CI,
  input logic rst,
  input logic axi_valid,
  input logic axi_ready,
  input logic clear,
  input logic full
);

  // Back-pressure holds while the log is full
  ready_low_when_full: assert property (@(posedge Clk_CI) disable iff (rst)
    !(axi_ready && full))
    else $error("axi_ready is high while full is high");

  // Address and metadata words use the two cycles after an accept
  ready_gap_after_accept: assert property (@(posedge Clk_CI) disable iff (rst || clear)
    (axi_valid && axi_ready) |=> !axi_ready ##1 !axi_ready)
    else $error("axi_ready came back within two cycles of an accept");

  // The log only empties through clear
  full_falls_on_clear: assert property (@(posedge Clk_CI) disable iff (rst)
    $fell(full) |-> $past(clear))
    else $error("full fell without a clear in the cycle before");

endmodule

/* tb/tb_axi_logger.sv */
`timescale 1ns/10ps
`include "logger_config.svh"

module tb_axi_logger;

  localparam int RESET_CYCLES = 16;
  localparam int B2B_BEATS    = 4;
  localparam int FULL_OFFERS  = 10;
  localparam int NUM_BEATS    = 1 + B2B_BEATS + `LOGGER_ENTRIES + FULL_OFFERS + 3;
  localparam int NUM_READS    = 1 + 3 + 3 * B2B_BEATS + 3 + 6;
  localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + 6 * NUM_BEATS + 2 * NUM_READS) * 20;
  localparam int LAST_ENTRY   = `LOGGER_WORDS - `LOGGER_WORDS_PER_ENTRY;
  localparam logic [31:0] SEED = 32'he759_093d;

  logic                  Clk_CI;
  logic                  rst;
  logic                  axi_valid;
  logic                  axi_ready;
  logger_pkg::axi_id_t   axi_id;
  logger_pkg::axi_addr_t axi_addr;
  logger_pkg::axi_len_t  axi_len;
  logic                  clear;
  logic                  full;
  logic                  rd_en;
  logger_pkg::log_addr_t rd_addr;
  logger_pkg::log_word_t rd_data;
  int                    error_count;
  int                    errors_before;
  int                    test_num;
  int                    tests_failed;

  axi_logger_top UUT (.*);

  logger_checker u_checker (.*);

  bind axi_logger_top logger_sva u_sva (
    .Clk_CI(Clk_CI), .rst(rst), .axi_valid(axi_valid),
    .axi_ready(axi_ready), .clear(clear), .full(full)
  );

  always #10 Clk_CI = ~Clk_CI;

  // Returns on the edge where the beat is accepted with valid still high
  task automatic send_beat();
    @(negedge Clk_CI);
    axi_valid = 1'b1;
    axi_id    = logger_pkg::axi_id_t'($urandom);
    axi_addr  = $urandom;
    axi_len   = logger_pkg::axi_len_t'($urandom);
    do begin
      @(posedge Clk_CI);
    end while (!axi_ready);
  endtask

  task automatic go_idle(input int cycles);
    @(negedge Clk_CI);
    axi_valid = 1'b0;
    repeat (cycles) @(negedge Clk_CI);
  endtask

  task automatic pulse_clear();
    @(negedge Clk_CI);
    axi_valid = 1'b0;
    clear     = 1'b1;
    @(negedge Clk_CI);
    clear     = 1'b0;
  endtask

  // Beats offered to a full log are never taken
  task automatic offer_while_full();
    repeat (FULL_OFFERS) begin
      @(negedge Clk_CI);
      axi_valid = 1'b1;
      axi_addr  = $urandom;
    end
  endtask

  task automatic read_words(input int first, input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge Clk_CI);
      rd_en   = 1'b1;
      rd_addr = logger_pkg::log_addr_t'(first + i);
    end
    @(negedge Clk_CI);
    rd_en = 1'b0;
    @(negedge Clk_CI);
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = error_count - errors_before;
    test_num++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", test_num, name, (errs == 0) ? "ok" : "FAILED", errs);
    errors_before = error_count;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0d ns before the tests completed", $time);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    Clk_CI       = 1'b0;
    rst          = 1'b1;
    axi_valid    = 1'b0;
    axi_id       = '0;
    axi_addr     = '0;
    axi_len      = '0;
    clear        = 1'b0;
    rd_en        = 1'b0;
    rd_addr      = '0;
    test_num     = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(negedge Clk_CI);
    rst = 1'b0;
    errors_before = error_count;

    go_idle(1);
    read_words(0, 1);
    report_test("after reset");

    send_beat();
    go_idle(4);
    read_words(0, 3);
    report_test("single beat");

    repeat (B2B_BEATS) send_beat();
    go_idle(4);
    read_words(3, 3 * B2B_BEATS);
    report_test("back-to-back beats");

    pulse_clear();
    repeat (`LOGGER_ENTRIES) send_beat();
    go_idle(4);
    offer_while_full();
    go_idle(2);
    read_words(LAST_ENTRY, 3);
    report_test("fill the log");

    // Clear while full, then clear in the middle of an entry
    pulse_clear();
    send_beat();
    go_idle(4);
    send_beat();
    pulse_clear();
    send_beat();
    go_idle(4);
    read_words(0, 6);
    report_test("clear");

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", test_num, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* verilog/axi_capture_fsm.sv */
`timescale 1ns/10ps
`include "logger_config.svh"

module axi_capture_fsm (
  input  logic                  Clk_CI,
  input  logic                  rst,

  // AXI address channel, observed beats
  input  logic                  axi_valid,
  output logic                  axi_ready,
  input  logger_pkg::axi_id_t   axi_id,
  input  logger_pkg::axi_addr_t axi_addr,
  input  logger_pkg::axi_len_t  axi_len,

  input  logic                  clear,

  log_write_if.capture          wr
);

  logger_pkg::capture_state_t state_q;
  logger_pkg::capture_state_t state_d;
  logger_pkg::timestamp_t     timestamp_q;
  logger_pkg::axi_addr_t      addr_q;
  logger_pkg::axi_id_t        id_q;
  logger_pkg::axi_len_t       len_q;
  logger_pkg::log_word_t      meta_word;
  logic                       accept;

  // Only take a new beat when the previous entry is complete
  assign axi_ready = (state_q == logger_pkg::IDLE) && !wr.full && !clear;
  assign accept    = axi_valid && axi_ready;

  // Clear is handled here only, the controller just sees restart
  assign wr.restart = clear;

  // Metadata word with ID and length, zero above
  always_comb begin
    meta_word = '0;
    meta_word[`LOGGER_META_ID_LSB +: `LOGGER_AXI_ID_WIDTH]   = id_q;
    meta_word[`LOGGER_META_LEN_LSB +: `LOGGER_AXI_LEN_WIDTH] = len_q;
  end

  always_comb begin
    state_d     = state_q;
    wr.wr_valid = 1'b0;
    wr.wr_data  = timestamp_q;

    if (clear) begin
      // Drop any partial entry
      state_d = logger_pkg::IDLE;
    end else begin
      case (state_q)
        logger_pkg::IDLE: begin
          if (accept) begin
            wr.wr_valid = 1'b1;
            wr.wr_data  = timestamp_q;
            state_d     = logger_pkg::WRITE_ADDR;
          end
        end
        logger_pkg::WRITE_ADDR: begin
          wr.wr_valid = 1'b1;
          wr.wr_data  = addr_q;
          state_d     = logger_pkg::WRITE_META;
        end
        logger_pkg::WRITE_META: begin
          wr.wr_valid = 1'b1;
          wr.wr_data  = meta_word;
          state_d     = logger_pkg::IDLE;
        end
        default: begin
          state_d = logger_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (rst) begin
      state_q <= logger_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Timestamp runs every cycle and wraps, clear leaves it alone
  always_ff @(posedge Clk_CI) begin
    if (rst) begin
      timestamp_q <= '0;
    end else begin
      timestamp_q <= timestamp_q + 1'b1;
    end
  end

  // Beat fields held for the two words after the accept
  always_ff @(posedge Clk_CI) begin
    if (accept) begin
      addr_q <= axi_addr;
      id_q   <= axi_id;
      len_q  <= axi_len;
    end
  end

endmodule

/* verilog/axi_logger_top.sv */
`timescale 1ns/10ps

module axi_logger_top (
  input  logic                  Clk_CI,
  input  logic                  rst,

  // AXI address channel to be logged
  input  logic                  axi_valid,
  output logic                  axi_ready,
  input  logger_pkg::axi_id_t   axi_id,
  input  logger_pkg::axi_addr_t axi_addr,
  input  logger_pkg::axi_len_t  axi_len,

  // Control and status
  input  logic                  clear,
  output logic                  full,

  // Host readback
  input  logic                  rd_en,
  input  logger_pkg::log_addr_t rd_addr,
  output logger_pkg::log_word_t rd_data
);

  // Write port between controller and memory
  logic                  mem_wr_en;
  logger_pkg::log_addr_t mem_wr_addr;
  logger_pkg::log_word_t mem_wr_data;

  log_write_if wr_if ();

  assign full = wr_if.full;

  // Timestamp, beat latch and entry sequencing
  axi_capture_fsm i_capture (
    .Clk_CI    (Clk_CI),
    .rst       (rst),
    .axi_valid (axi_valid),
    .axi_ready (axi_ready),
    .axi_id    (axi_id),
    .axi_addr  (axi_addr),
    .axi_len   (axi_len),
    .clear     (clear),
    .wr        (wr_if.capture)
  );

  // Word counter and full flag
  log_write_ctrl i_write_ctrl (
    .Clk_CI      (Clk_CI),
    .rst         (rst),
    .wr          (wr_if.ctrl),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data)
  );

  log_mem i_log_mem (
    .Clk_CI  (Clk_CI),
    .rst     (rst),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* verilog/log_mem.sv */
`timescale 1ns/10ps
`include "logger_config.svh"

module log_mem (
  input  logic                  Clk_CI,
  input  logic                  rst,

  // Write port, driven by the write controller
  input  logic                  wr_en,
  input  logger_pkg::log_addr_t wr_addr,
  input  logger_pkg::log_word_t wr_data,

  // Host read port, one cycle latency
  input  logic                  rd_en,
  input  logger_pkg::log_addr_t rd_addr,
  output logger_pkg::log_word_t rd_data
);

  logger_pkg::log_word_t mem [`LOGGER_WORDS];

  // Block RAM powers up with all words at zero
  initial begin
    for (int i = 0; i < `LOGGER_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read before write on an address collision
  always_ff @(posedge Clk_CI) begin
    if (rst) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* verilog/log_write_ctrl.sv */
`timescale 1ns/10ps
`include "logger_config.svh"

module log_write_ctrl (
  input  logic                  Clk_CI,
  input  logic                  rst,

  log_write_if.ctrl             wr,

  // Write port of the log memory
  output logic                  mem_wr_en,
  output logger_pkg::log_addr_t mem_wr_addr,
  output logger_pkg::log_word_t mem_wr_data
);

  // Address of the last word in the memory
  localparam logger_pkg::log_addr_t LAST_ADDR = logger_pkg::log_addr_t'(`LOGGER_WORDS - 1);

  logger_pkg::log_addr_t wr_cnt;
  logic                  full_q;
  logic                  take_word;

  // Words offered after the log filled up are ignored
  assign take_word = wr.wr_valid && !full_q && !wr.restart;

  assign wr.full = full_q;

  // Offered words go straight to the memory write port
  assign mem_wr_en   = take_word;
  assign mem_wr_addr = wr_cnt;
  assign mem_wr_data = wr.wr_data;

  // Word counter and full flag
  always_ff @(posedge Clk_CI) begin
    if (rst) begin
      wr_cnt <= '0;
      full_q <= 1'b0;
    end else if (wr.restart) begin
      wr_cnt <= '0;
      full_q <= 1'b0;
    end else if (take_word) begin
      wr_cnt <= wr_cnt + 1'b1;
      // Counter reaches LOGGER_WORDS with this word
      if (wr_cnt == LAST_ADDR) begin
        full_q <= 1'b1;
      end
    end
  end

endmodule

/* verilog/log_write_if.sv */
`timescale 1ns/10ps

// Word stream from the capture sequencer to the write controller
// The controller takes every offered word, so there is no ready
interface log_write_if;

  // Word offered for the log in this cycle
  logic                  wr_valid;
  logger_pkg::log_word_t wr_data;

  // Empties the log, word counter back to 0
  logic                  restart;

  // Log holds LOGGER_ENTRIES entries
  logic                  full;

  modport capture (
    output wr_valid,
    output wr_data,
    output restart,
    input  full
  );

  modport ctrl (
    input  wr_valid,
    input  wr_data,
    input  restart,
    output full
  );

endinterface

/* verilog/logger_config.svh */
`ifndef LOGGER_CONFIG_SVH
`define LOGGER_CONFIG_SVH

// AXI address channel fields
`define LOGGER_AXI_ADDR_WIDTH 32
`define LOGGER_AXI_ID_WIDTH 8
`define LOGGER_AXI_LEN_WIDTH 8

// Log word and timestamp
`define LOGGER_DATA_WIDTH 32
`define LOGGER_TS_WIDTH 32

// Log memory geometry
`define LOGGER_WORDS_PER_ENTRY 3
`define LOGGER_ENTRIES 64
`define LOGGER_WORDS (`LOGGER_WORDS_PER_ENTRY * `LOGGER_ENTRIES)
`define LOGGER_ADDR_WIDTH 8

// Bit positions inside the metadata word, upper bits are zero
`define LOGGER_META_LEN_LSB 0
`define LOGGER_META_ID_LSB 8

`endif

/* verilog/logger_pkg.sv */
`include "logger_config.svh"

package logger_pkg;

  // AXI address channel fields
  typedef logic [`LOGGER_AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`LOGGER_AXI_ID_WIDTH-1:0]   axi_id_t;
  typedef logic [`LOGGER_AXI_LEN_WIDTH-1:0]  axi_len_t;

  // One word of the log memory
  typedef logic [`LOGGER_DATA_WIDTH-1:0] log_word_t;

  // Free-running cycle count stored as word 0 of an entry
  typedef logic [`LOGGER_TS_WIDTH-1:0] timestamp_t;

  // Word address into the log memory
  typedef logic [`LOGGER_ADDR_WIDTH-1:0] log_addr_t;

  // Capture sequence, one state per word of an entry
  // IDLE also emits the timestamp word on an accept
  typedef enum logic [1:0] {
    IDLE,
    WRITE_ADDR,
    WRITE_META
  } capture_state_t;

endpackage

/* vlog.f */
+incdir+verilog
verilog/logger_pkg.sv
verilog/log_write_if.sv
verilog/axi_capture_fsm.sv
verilog/log_write_ctrl.sv
verilog/log_mem.sv
verilog/axi_logger_top.sv
tb/logger_sva.sv
tb/logger_checker.sv
tb/tb_axi_logger.sv
